//--- rtl/dac_consts.svh
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

// Bits in one complete SPI frame
`define DAC_FRAME_BITS 32

// Field positions inside the shift word, bit 31 was shifted in first
`define DAC_CMD_MSB  23
`define DAC_CMD_LSB  20
`define DAC_ADDR_MSB 19
`define DAC_ADDR_LSB 16
`define DAC_CODE_MSB 15
`define DAC_CODE_LSB 4

// Command codes
`define DAC_CMD_WRITE         4'b0000
`define DAC_CMD_UPDATE        4'b0001
`define DAC_CMD_WRITE_UPD_ALL 4'b0010
`define DAC_CMD_WRITE_UPD     4'b0011
`define DAC_CMD_POWER_DOWN    4'b0100
`define DAC_CMD_NOP           4'b1111

// Address that selects every channel at once
`define DAC_ADDR_ALL 4'b1111

// Channel count, A to D
`define DAC_NUM_CH 4

`endif

//--- rtl/dac_pkg.sv
`include "dac_consts.svh"

package dac_pkg;

   // One converter code, as carried in the frame
   typedef logic [`DAC_CODE_MSB-`DAC_CODE_LSB:0] dac_code_t;

   // Command nibble
   typedef logic [`DAC_CMD_MSB-`DAC_CMD_LSB:0] dac_cmd_t;

   // Address nibble
   typedef logic [`DAC_ADDR_MSB-`DAC_ADDR_LSB:0] dac_addr_t;

   // Whole shift register contents
   typedef logic [`DAC_FRAME_BITS-1:0] dac_word_t;

   // Bit counter, wide enough to saturate well above one frame
   typedef logic [5:0] dac_bitcnt_t;

   // One bit per channel, bit 0 is channel A
   typedef logic [`DAC_NUM_CH-1:0] dac_ch_mask_t;

   // Shifter states
   // Idle while cs_n is high, shift while a frame runs
   typedef enum logic {
      FRAME_IDLE,
      FRAME_SHIFT
   } frame_state_e;

endpackage

//--- rtl/dac_spi_shifter.sv
`timescale 1ns/1ns

module dac_spi_shifter (
   input  logic                 SPI_SCK,
   input  logic                 arst_n,
   input  logic                 cs_n,
   input  logic                 sdi,
   output logic                 sdo,
   output logic                 frame_done,
   output dac_pkg::dac_word_t   frame_word,
   output dac_pkg::dac_bitcnt_t frame_bits
);

   // Frame tracking state
   dac_pkg::frame_state_e state;

   // Counter limit, the counter holds here on overlong frames
   localparam dac_pkg::dac_bitcnt_t BITCNT_MAX = '1;

   // Index of the word MSB
   localparam int WORD_MSB = $bits(dac_pkg::dac_word_t) - 1;

   // Frame state machine and bit counter
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         state      <= dac_pkg::FRAME_IDLE;
         frame_bits <= '0;
         frame_done <= 1'b0;
      end else begin
         // End-of-frame strobe lasts a single cycle
         frame_done <= 1'b0;
         case (state)
            dac_pkg::FRAME_IDLE: begin
               // First low sample opens a frame and counts its first bit
               if (!cs_n) begin
                  state      <= dac_pkg::FRAME_SHIFT;
                  frame_bits <= dac_pkg::dac_bitcnt_t'(1);
               end
            end
            dac_pkg::FRAME_SHIFT: begin
               if (cs_n) begin
                  // First high sample closes the frame
                  state      <= dac_pkg::FRAME_IDLE;
                  frame_done <= 1'b1;
               end else if (frame_bits != BITCNT_MAX) begin
                  frame_bits <= frame_bits + dac_pkg::dac_bitcnt_t'(1);
               end
            end
         endcase
      end
   end

   // Shift register, MSB first
   // Never cleared between frames so the old word drains out on sdo
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         frame_word <= '0;
      end else if (!cs_n) begin
         frame_word <= {frame_word[WORD_MSB-1:0], sdi};
      end
   end

   // Daisy-chain output
   // Word MSB while selected, low otherwise
   assign sdo = cs_n ? 1'b0 : frame_word[WORD_MSB];

endmodule

//--- rtl/dac_cmd_decoder.sv
`timescale 1ns/1ns

`include "dac_consts.svh"

module dac_cmd_decoder (
   input  logic                  SPI_SCK,
   input  logic                  arst_n,
   input  logic                  frame_done,
   input  dac_pkg::dac_word_t    frame_word,
   input  dac_pkg::dac_bitcnt_t  frame_bits,
   output dac_pkg::dac_ch_mask_t ch_mask,
   output dac_pkg::dac_code_t    code,
   output logic                  load_input,
   output dac_pkg::dac_ch_mask_t load_dac,
   output logic                  pwr_off,
   output logic                  frame_err,
   output logic                  cmd_err
);

   // Fields of the finished frame
   dac_pkg::dac_cmd_t     cmd;
   dac_pkg::dac_addr_t    addr;
   dac_pkg::dac_code_t    frame_code;

   // Decode results
   dac_pkg::dac_ch_mask_t addr_mask;
   logic                  addr_ok;
   logic                  cmd_ok;
   logic                  bits_ok;
   logic                  exec;

   // Next values of the registered strobes
   logic                  nxt_load_input;
   dac_pkg::dac_ch_mask_t nxt_load_dac;
   logic                  nxt_pwr_off;

   assign cmd        = frame_word[`DAC_CMD_MSB:`DAC_CMD_LSB];
   assign addr       = frame_word[`DAC_ADDR_MSB:`DAC_ADDR_LSB];
   assign frame_code = frame_word[`DAC_CODE_MSB:`DAC_CODE_LSB];

   assign bits_ok = (frame_bits == dac_pkg::dac_bitcnt_t'(`DAC_FRAME_BITS));

   // Address to channel mask
   always_comb begin
      addr_ok = 1'b1;
      case (addr)
         4'd0:          addr_mask = 4'b0001;
         4'd1:          addr_mask = 4'b0010;
         4'd2:          addr_mask = 4'b0100;
         4'd3:          addr_mask = 4'b1000;
         `DAC_ADDR_ALL: addr_mask = '1;
         default: begin
            addr_mask = '0;
            addr_ok   = 1'b0;
         end
      endcase
   end

   // Only the six known commands are accepted
   always_comb begin
      case (cmd)
         `DAC_CMD_WRITE,
         `DAC_CMD_UPDATE,
         `DAC_CMD_WRITE_UPD_ALL,
         `DAC_CMD_WRITE_UPD,
         `DAC_CMD_POWER_DOWN,
         `DAC_CMD_NOP: cmd_ok = 1'b1;
         default:      cmd_ok = 1'b0;
      endcase
   end

   // A complete, well formed frame is executed
   assign exec = frame_done && bits_ok && addr_ok && cmd_ok;

   // Strobe selection per command
   // NOP falls through with nothing set
   always_comb begin
      nxt_load_input = 1'b0;
      nxt_load_dac   = '0;
      nxt_pwr_off    = 1'b0;
      if (exec) begin
         case (cmd)
            `DAC_CMD_WRITE:      nxt_load_input = 1'b1;
            `DAC_CMD_UPDATE:     nxt_load_dac   = addr_mask;
            `DAC_CMD_POWER_DOWN: nxt_pwr_off    = 1'b1;
            `DAC_CMD_WRITE_UPD: begin
               nxt_load_input = 1'b1;
               nxt_load_dac   = addr_mask;
            end
            // Input register of the addressed channel and update of every channel
            `DAC_CMD_WRITE_UPD_ALL: begin
               nxt_load_input = 1'b1;
               nxt_load_dac   = '1;
            end
            default: ;
         endcase
      end
   end

   // Registered strobes one cycle behind frame_done
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         load_input <= 1'b0;
         load_dac   <= '0;
         pwr_off    <= 1'b0;
         frame_err  <= 1'b0;
         cmd_err    <= 1'b0;
      end else begin
         load_input <= nxt_load_input;
         load_dac   <= nxt_load_dac;
         pwr_off    <= nxt_pwr_off;
         frame_err  <= frame_done && !bits_ok;
         cmd_err    <= frame_done && bits_ok && !(addr_ok && cmd_ok);
      end
   end

   // Mask and code travel alongside the strobes
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         ch_mask <= '0;
         code    <= '0;
      end else if (frame_done) begin
         ch_mask <= addr_mask;
         code    <= frame_code;
      end
   end

endmodule

//--- rtl/dac_channel_regs.sv
`timescale 1ns/1ns

`include "dac_consts.svh"

module dac_channel_regs (
   input  logic                  SPI_SCK,
   input  logic                  arst_n,
   input  logic                  clr_n,
   input  dac_pkg::dac_ch_mask_t ch_mask,
   input  dac_pkg::dac_code_t    code,
   input  logic                  load_input,
   input  dac_pkg::dac_ch_mask_t load_dac,
   input  logic                  pwr_off,
   output dac_pkg::dac_code_t    dac_code_a,
   output dac_pkg::dac_code_t    dac_code_b,
   output dac_pkg::dac_code_t    dac_code_c,
   output dac_pkg::dac_code_t    dac_code_d,
   output dac_pkg::dac_ch_mask_t power_down
);

   // Per channel input and DAC registers, index 0 is channel A
   dac_pkg::dac_code_t    input_reg [`DAC_NUM_CH];
   dac_pkg::dac_code_t    dac_reg   [`DAC_NUM_CH];
   dac_pkg::dac_ch_mask_t pd_flags;

   // Channels whose input register takes the new code this cycle
   dac_pkg::dac_ch_mask_t wr_mask;

   assign wr_mask = load_input ? ch_mask : '0;

   // Input registers
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            input_reg[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            // Clear wins over any write
            if (!clr_n) begin
               input_reg[i] <= '0;
            end else if (wr_mask[i]) begin
               input_reg[i] <= code;
            end
         end
      end
   end

   // DAC registers
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            dac_reg[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            if (!clr_n) begin
               dac_reg[i] <= '0;
            end else if (load_dac[i]) begin
               // Write and update together bypass the input register
               if (wr_mask[i]) begin
                  dac_reg[i] <= code;
               end else begin
                  dac_reg[i] <= input_reg[i];
               end
            end
         end
      end
   end

   // Power-down flags
   // An update powers the channel back up
   always_ff @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         pd_flags <= '0;
      end else if (!clr_n) begin
         pd_flags <= '0;
      end else begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            if (load_dac[i]) begin
               pd_flags[i] <= 1'b0;
            end else if (pwr_off && ch_mask[i]) begin
               pd_flags[i] <= 1'b1;
            end
         end
      end
   end

   // Channel outputs
   assign dac_code_a = dac_reg[0];
   assign dac_code_b = dac_reg[1];
   assign dac_code_c = dac_reg[2];
   assign dac_code_d = dac_reg[3];
   assign power_down = pd_flags;

endmodule

//--- rtl/dac_spi_top.sv
`timescale 1ns/1ns

module dac_spi_top (
   input  logic                  SPI_SCK,
   input  logic                  arst_n,
   input  logic                  cs_n,
   input  logic                  sdi,
   input  logic                  clr_n,
   output logic                  sdo,
   output dac_pkg::dac_code_t    dac_code_a,
   output dac_pkg::dac_code_t    dac_code_b,
   output dac_pkg::dac_code_t    dac_code_c,
   output dac_pkg::dac_code_t    dac_code_d,
   output dac_pkg::dac_ch_mask_t power_down,
   output logic                  frame_err,
   output logic                  cmd_err
);

   // Shifter to decoder
   logic                  frame_done;
   dac_pkg::dac_word_t    frame_word;
   dac_pkg::dac_bitcnt_t  frame_bits;

   // Decoder to channel registers
   dac_pkg::dac_ch_mask_t ch_mask;
   dac_pkg::dac_code_t    code;
   logic                  load_input;
   dac_pkg::dac_ch_mask_t load_dac;
   logic                  pwr_off;

   // Serial front end
   dac_spi_shifter shifter_i (
      .SPI_SCK    (SPI_SCK),
      .arst_n     (arst_n),
      .cs_n       (cs_n),
      .sdi        (sdi),
      .sdo        (sdo),
      .frame_done (frame_done),
      .frame_word (frame_word),
      .frame_bits (frame_bits)
   );

   // Frame check and command decode
   dac_cmd_decoder decoder_i (
      .SPI_SCK    (SPI_SCK),
      .arst_n     (arst_n),
      .frame_done (frame_done),
      .frame_word (frame_word),
      .frame_bits (frame_bits),
      .ch_mask    (ch_mask),
      .code       (code),
      .load_input (load_input),
      .load_dac   (load_dac),
      .pwr_off    (pwr_off),
      .frame_err  (frame_err),
      .cmd_err    (cmd_err)
   );

   // Input and DAC register banks
   dac_channel_regs regs_i (
      .SPI_SCK    (SPI_SCK),
      .arst_n     (arst_n),
      .clr_n      (clr_n),
      .ch_mask    (ch_mask),
      .code       (code),
      .load_input (load_input),
      .load_dac   (load_dac),
      .pwr_off    (pwr_off),
      .dac_code_a (dac_code_a),
      .dac_code_b (dac_code_b),
      .dac_code_c (dac_code_c),
      .dac_code_d (dac_code_d),
      .power_down (power_down)
   );

endmodule

//--- dv/dac_spi_checker.sv
`timescale 1ns/1ns

`include "dac_consts.svh"

module dac_spi_checker (
   input  logic                  SPI_SCK,
   input  logic                  arst_n,
   input  logic                  cs_n,
   input  logic                  sdi,
   input  logic                  clr_n,
   input  dac_pkg::dac_code_t    dac_code_a,
   input  dac_pkg::dac_code_t    dac_code_b,
   input  dac_pkg::dac_code_t    dac_code_c,
   input  dac_pkg::dac_code_t    dac_code_d,
   input  dac_pkg::dac_ch_mask_t power_down,
   input  logic                  frame_err,
   input  logic                  cmd_err,
   output int                    value_errs,
   output int                    strobe_errs
);

   // Reference model of the four channels, index 0 is channel A
   dac_pkg::dac_code_t    in_m  [`DAC_NUM_CH];
   dac_pkg::dac_code_t    dac_m [`DAC_NUM_CH];
   dac_pkg::dac_ch_mask_t pd_m;

   // Frame rebuilt from the pins
   dac_pkg::dac_word_t    sh;
   int                    nbits;
   logic                  in_frame;

   // Decoded frame, acted on two edges after cs_n rises
   int                    pend;
   dac_pkg::dac_cmd_t     act_cmd;
   dac_pkg::dac_ch_mask_t act_mask;
   dac_pkg::dac_code_t    act_code;
   logic                  act_ok;
   logic                  exp_ferr;
   logic                  exp_cerr;
   logic                  cmp_due;

   int                    n_value = 0;
   int                    n_strobe = 0;

   assign value_errs  = n_value;
   assign strobe_errs = n_strobe;

   // Frame rules: length first, then address and command
   task automatic decode_frame();
      logic cmd_known;
      act_cmd  = sh[`DAC_CMD_MSB:`DAC_CMD_LSB];
      act_code = sh[`DAC_CODE_MSB:`DAC_CODE_LSB];
      case (sh[`DAC_ADDR_MSB:`DAC_ADDR_LSB])
         4'd0, 4'd1, 4'd2, 4'd3: act_mask = 4'b0001 << sh[`DAC_ADDR_MSB:`DAC_ADDR_LSB];
         `DAC_ADDR_ALL:          act_mask = 4'b1111;
         default:                act_mask = 4'b0000;
      endcase
      cmd_known = act_cmd inside {`DAC_CMD_WRITE, `DAC_CMD_UPDATE, `DAC_CMD_WRITE_UPD_ALL,
                                  `DAC_CMD_WRITE_UPD, `DAC_CMD_POWER_DOWN, `DAC_CMD_NOP};
      exp_ferr = (nbits != `DAC_FRAME_BITS);
      exp_cerr = !exp_ferr && (act_mask == 4'b0000 || !cmd_known);
      act_ok   = !exp_ferr && !exp_cerr;
   endtask

   // Command effects on the model
   task automatic apply_action();
      for (int i = 0; i < `DAC_NUM_CH; i++) begin
         case (act_cmd)
            `DAC_CMD_WRITE: begin
               if (act_mask[i]) in_m[i] = act_code;
            end
            `DAC_CMD_UPDATE: begin
               if (act_mask[i]) begin
                  dac_m[i] = in_m[i];
                  pd_m[i]  = 1'b0;
               end
            end
            `DAC_CMD_WRITE_UPD: begin
               if (act_mask[i]) begin
                  in_m[i]  = act_code;
                  dac_m[i] = act_code;
                  pd_m[i]  = 1'b0;
               end
            end
            // Addressed input registers take the code, every channel updates
            `DAC_CMD_WRITE_UPD_ALL: begin
               if (act_mask[i]) in_m[i] = act_code;
               dac_m[i] = in_m[i];
               pd_m[i]  = 1'b0;
            end
            `DAC_CMD_POWER_DOWN: begin
               if (act_mask[i]) pd_m[i] = 1'b1;
            end
            default: ;
         endcase
      end
   endtask

   // Model update on the rising edge, same edge as the DUT registers
   always @(posedge SPI_SCK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `DAC_NUM_CH; i++) begin
            in_m[i]  = '0;
            dac_m[i] = '0;
         end
         pd_m     = '0;
         sh       = '0;
         nbits    = 0;
         in_frame = 1'b0;
         pend     = 0;
         exp_ferr = 1'b0;
         exp_cerr = 1'b0;
         act_ok   = 1'b0;
         cmp_due  = 1'b0;
      end else begin
         cmp_due = 1'b0;
         if (pend == 1) begin
            if (act_ok) apply_action();
            cmp_due = 1'b1;
         end
         if (pend > 0) pend = pend - 1;
         // Clear wins over a command landing on the same edge
         if (!clr_n) begin
            for (int i = 0; i < `DAC_NUM_CH; i++) begin
               in_m[i]  = '0;
               dac_m[i] = '0;
            end
            pd_m    = '0;
            cmp_due = 1'b1;
         end
         if (!cs_n) begin
            if (!in_frame) nbits = 0;
            in_frame = 1'b1;
            sh       = {sh[`DAC_FRAME_BITS-2:0], sdi};
            if (nbits < 63) nbits++;
         end else if (in_frame) begin
            in_frame = 1'b0;
            decode_frame();
            pend = 2;
         end
      end
   end

   task automatic check_value(input string name, input logic [11:0] got,
                              input logic [11:0] exp);
      if (got !== exp) begin
         n_value++;
         $display("Fail %s at %0t ns: got 0x%h, expected 0x%h", name, $time, got, exp);
      end
   endtask

   task automatic check_strobe(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         n_strobe++;
         if (exp) $display("Missing %s strobe after the frame ending near %0t ns", name, $time);
         else     $display("Unexpected %s strobe at %0t ns", name, $time);
      end
   endtask

   // Compare mid-cycle, away from the rising edge
   always @(negedge SPI_SCK) begin
      if (arst_n) begin
         // Error strobes live in the cycle after frame_done only
         check_strobe("frame_err", frame_err, pend == 1 && exp_ferr);
         check_strobe("cmd_err", cmd_err, pend == 1 && exp_cerr);
         if (cmp_due) begin
            check_value("dac_code_a", dac_code_a, dac_m[0]);
            check_value("dac_code_b", dac_code_b, dac_m[1]);
            check_value("dac_code_c", dac_code_c, dac_m[2]);
            check_value("dac_code_d", dac_code_d, dac_m[3]);
            check_value("power_down", {8'h00, power_down}, {8'h00, pd_m});
         end
      end
   end

endmodule

//--- dv/dac_spi_tb.sv
`timescale 1ns/1ns

module dac_spi_tb;

   // One frame of stimulus and the outputs expected after it
   typedef struct packed {
      int          bits;
      logic        clr;
      logic [3:0]  cmd;
      logic [3:0]  addr;
      logic [11:0] code;
      logic [11:0] exp_a;
      logic [11:0] exp_b;
      logic [11:0] exp_c;
      logic [11:0] exp_d;
      logic [3:0]  exp_pd;
   } stim_t;

   localparam int HALF_PERIOD = 50;

   logic                  SPI_SCK = 1'b0;
   logic                  arst_n;
   logic                  cs_n;
   logic                  sdi;
   logic                  clr_n;
   logic                  sdo;
   dac_pkg::dac_code_t    dac_code_a;
   dac_pkg::dac_code_t    dac_code_b;
   dac_pkg::dac_code_t    dac_code_c;
   dac_pkg::dac_code_t    dac_code_d;
   dac_pkg::dac_ch_mask_t power_down;
   logic                  frame_err;
   logic                  cmd_err;

   stim_t                 stim_q[$];
   bit                    stim_ready = 1'b0;
   int                    line_no;
   // Shift word as the DUT should hold it
   // Its MSB is the next sdo bit
   logic [31:0]           shadow;
   int                    sdo_errs;
   int                    exp_errs;
   int                    value_errs;
   int                    strobe_errs;

   // 100 ns clock
   always #HALF_PERIOD SPI_SCK = ~SPI_SCK;

   dac_spi_top dut_i (
      .SPI_SCK    (SPI_SCK),
      .arst_n     (arst_n),
      .cs_n       (cs_n),
      .sdi        (sdi),
      .clr_n      (clr_n),
      .sdo        (sdo),
      .dac_code_a (dac_code_a),
      .dac_code_b (dac_code_b),
      .dac_code_c (dac_code_c),
      .dac_code_d (dac_code_d),
      .power_down (power_down),
      .frame_err  (frame_err),
      .cmd_err    (cmd_err)
   );

   dac_spi_checker checker_i (
      .SPI_SCK     (SPI_SCK),
      .arst_n      (arst_n),
      .cs_n        (cs_n),
      .sdi         (sdi),
      .clr_n       (clr_n),
      .dac_code_a  (dac_code_a),
      .dac_code_b  (dac_code_b),
      .dac_code_c  (dac_code_c),
      .dac_code_d  (dac_code_d),
      .power_down  (power_down),
      .frame_err   (frame_err),
      .cmd_err     (cmd_err),
      .value_errs  (value_errs),
      .strobe_errs (strobe_errs)
   );

   // Lines starting with # are skipped
   function automatic bit load_stim();
      int    fd;
      int    n;
      string line;
      int    f_bits, f_clr, f_cmd, f_addr, f_code, f_a, f_b, f_c, f_d, f_pd;
      stim_t s;
      fd = $fopen("dv/dac_stim.txt", "r");
      if (fd == 0) return 1'b0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#") begin
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", f_bits, f_clr, f_cmd,
                        f_addr, f_code, f_a, f_b, f_c, f_d, f_pd);
            if (n == 10) begin
               s = '{f_bits, f_clr[0], f_cmd[3:0], f_addr[3:0], f_code[11:0],
                     f_a[11:0], f_b[11:0], f_c[11:0], f_d[11:0], f_pd[3:0]};
               stim_q.push_back(s);
            end
         end
      end
      $fclose(fd);
      return stim_q.size() > 0;
   endfunction

   task automatic compare_field(input string name, input logic [11:0] got,
                                input logic [11:0] exp);
      if (got !== exp) begin
         exp_errs++;
         $display("Fail %s after stim line %0d: got 0x%h, expected 0x%h",
                  name, line_no, got, exp);
      end
   endtask

   // Optional clear cycle, the frame bits and three idle cycles
   // Entered on a falling edge
   task automatic send_frame(input stim_t s);
      logic [31:0] word;
      logic [31:0] dc;
      logic [31:0] extra;
      logic        b;
      dc    = $urandom;
      extra = $urandom;
      word  = {dc[7:0], s.cmd, s.addr, s.code, dc[11:8]};
      if (s.clr) begin
         clr_n = 1'b0;
         @(negedge SPI_SCK);
         clr_n = 1'b1;
      end
      for (int k = 0; k < s.bits; k++) begin
         // Bits past the 32nd are random filler
         b    = (k < 32) ? word[31-k] : extra[k-32];
         cs_n = 1'b0;
         sdi  = b;
         // sdo is settled halfway through the low phase
         #(HALF_PERIOD / 2);
         if (sdo !== shadow[31]) begin
            sdo_errs++;
            $display("Fail sdo on stim line %0d bit %0d: got 0x%h, expected 0x%h",
                     line_no, k, sdo, shadow[31]);
         end
         @(posedge SPI_SCK);
         shadow = {shadow[30:0], b};
         @(negedge SPI_SCK);
      end
      cs_n = 1'b1;
      sdi  = 1'b0;
      repeat (3) @(negedge SPI_SCK);
      compare_field("dac_code_a", dac_code_a, s.exp_a);
      compare_field("dac_code_b", dac_code_b, s.exp_b);
      compare_field("dac_code_c", dac_code_c, s.exp_c);
      compare_field("dac_code_d", dac_code_d, s.exp_d);
      compare_field("power_down", {8'h00, power_down}, {8'h00, s.exp_pd});
   endtask

   // Watchdog allows 40 cycles per frame plus 100 more
   initial begin
      wait (stim_ready);
      repeat (stim_q.size() * 40 + 100) @(posedge SPI_SCK);
      $display("Timeout: the run did not end within the allowed number of cycles");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      int seed_out;
      arst_n   = 1'b0;
      cs_n     = 1'b1;
      sdi      = 1'b0;
      clr_n    = 1'b1;
      shadow   = '0;
      sdo_errs = 0;
      exp_errs = 0;
      line_no  = 0;
      seed_out = $urandom(32'h8233);
      if (!load_stim()) begin
         $display("Stimulus file dv/dac_stim.txt could not be read or holds no frames");
         $display("FAIL: see errors above");
         $finish;
      end else begin
         stim_ready = 1'b1;
         repeat (5) @(negedge SPI_SCK);
         arst_n = 1'b1;
         @(negedge SPI_SCK);
         foreach (stim_q[i]) begin
            line_no = i;
            send_frame(stim_q[i]);
         end
         repeat (2) @(negedge SPI_SCK);
         $display("Errors: %0d value, %0d strobe, %0d sdo, %0d against stim file",
                  value_errs, strobe_errs, sdo_errs, exp_errs);
         if (value_errs + strobe_errs + sdo_errs + exp_errs == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

endmodule

//--- dv/dac_stim.txt
# bits(dec) clr cmd addr code, then expected dac_code_a b c d and power_down, all hex
# cmd 0 write, 1 update, 2 write+update all, 3 write+update, 4 power down, f no-op
# Write and update each channel, then all four
32 0 3 0 123 123 000 000 000 0
32 0 3 1 456 123 456 000 000 0
32 0 3 2 789 123 456 789 000 0
32 0 3 3 abc 123 456 789 abc 0
32 0 3 f 5a5 5a5 5a5 5a5 5a5 0
# Write alone, update, write+update all from channel A
32 0 0 1 111 5a5 5a5 5a5 5a5 0
32 0 1 1 000 5a5 111 5a5 5a5 0
32 0 0 2 222 5a5 111 5a5 5a5 0
32 0 2 0 333 333 111 222 5a5 0
# Bad length, bad address, bad command, no-op
31 0 3 0 fff 333 111 222 5a5 0
33 0 3 1 fff 333 111 222 5a5 0
32 0 3 5 777 333 111 222 5a5 0
32 0 7 0 777 333 111 222 5a5 0
32 0 f 0 777 333 111 222 5a5 0
# Power down and wake up
32 0 4 1 000 333 111 222 5a5 2
32 0 4 f 000 333 111 222 5a5 f
32 0 1 0 000 333 111 222 5a5 e
32 0 3 2 444 333 111 444 5a5 a
# Clear, then update gives zero
32 1 1 f 000 000 000 000 000 0
32 0 3 3 0c3 000 000 000 0c3 0
32 0 4 3 000 000 000 000 0c3 8
32 1 f 0 000 000 000 000 000 0
32 0 2 f 9e1 9e1 9e1 9e1 9e1 0
32 0 1 3 000 9e1 9e1 9e1 9e1 0

//--- compile.f
+incdir+rtl
rtl/dac_pkg.sv
rtl/dac_spi_shifter.sv
rtl/dac_cmd_decoder.sv
rtl/dac_channel_regs.sv
rtl/dac_spi_top.sv
dv/dac_spi_checker.sv
dv/dac_spi_tb.sv

//--- Makefile
TOP := dac_spi_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module dac_spi_top

# Pass or fail comes from the log, not from the simulator exit code
sim:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
